/* include/enc_consts.svh */
`ifndef ENC_CONSTS_SVH
`define ENC_CONSTS_SVH

// frame size in 4x4 blocks
`define FRAME_W_BLK 4
`define FRAME_H_BLK 3

// fixed quantizer step
`define ENC_QP 27

// datapath widths
`define PIX_W 8
`define LEVEL_W 13
`define CODE_W 32
`define LEN_W 6

`endif

/* hw/enc_pkg.sv */
package enc_pkg;

    // multipliers per qp%6, element 0 is qp%6 == 0
    localparam logic [5:0][15:0] MF_CLS0 = {
        16'd7282, 16'd8192, 16'd9362, 16'd10082, 16'd11916, 16'd13107
    };
    localparam logic [5:0][15:0] MF_CLS1 = {
        16'd2893, 16'd3355, 16'd3647, 16'd4194, 16'd4660, 16'd5243
    };
    localparam logic [5:0][15:0] MF_CLS2 = {
        16'd4559, 16'd5243, 16'd5825, 16'd6554, 16'd7490, 16'd8066
    };

    // raster index {row, col} per scan index, element 0 is scan index 0
    localparam logic [15:0][3:0] ZIGZAG = {
        4'd15, 4'd14, 4'd11, 4'd7, 4'd10, 4'd13, 4'd12, 4'd9,
        4'd6, 4'd3, 4'd2, 4'd5, 4'd8, 4'd4, 4'd1, 4'd0
    };

    // class 0: both even, class 1: both odd, class 2: mixed
    function automatic int quant_mf(input int qp_mod, input int cls);
        case (cls)
            0: return int'(MF_CLS0[qp_mod]);
            1: return int'(MF_CLS1[qp_mod]);
            default: return int'(MF_CLS2[qp_mod]);
        endcase
    endfunction

    function automatic int quant_bits(input int qp);
        return 15 + qp / 6;
    endfunction

    function automatic logic [3:0] zigzag_pos(input logic [3:0] idx);
        return ZIGZAG[idx];
    endfunction

endpackage

/* hw/enc_if.sv */
`timescale 1ns/100ps
`include "enc_consts.svh"

// one 4x4 block of original pixels, raster order
interface blk_if;
    logic                       valid;
    logic                       ready;
    logic [7:0]                 blk_x;
    logic [7:0]                 blk_y;
    logic [15:0][`PIX_W-1:0]    pix;

    modport src (
        output valid, blk_x, blk_y, pix,
        input  ready
    );
    modport dst (
        input  valid, blk_x, blk_y, pix,
        output ready
    );
endinterface

// one block of quantized levels, raster order
interface coef_if;
    logic                       valid;
    logic                       ready;
    logic                       last;
    logic [15:0][`LEVEL_W-1:0]  level;

    modport src (
        output valid, last, level,
        input  ready
    );
    modport dst (
        input  valid, last, level,
        output ready
    );
endinterface

// one variable length codeword, right aligned
interface code_if;
    logic                       valid;
    logic                       ready;
    logic [`CODE_W-1:0]         code;
    logic [`LEN_W-1:0]          len;
    logic                       last;

    modport src (
        output valid, code, len, last,
        input  ready
    );
    modport dst (
        input  valid, code, len, last,
        output ready
    );
endinterface

/* hw/block_fetch.sv */
`timescale 1ns/100ps
`include "enc_consts.svh"

module block_fetch (
    input  logic        clk,
    input  logic        reset_i,
    input  logic        start_i,
    input  logic        data_valid_i,
    input  logic [31:0] data_word_i,
    output logic        fetch_req_o,
    output logic [31:0] fetch_addr_o,
    blk_if.src          blk,
    output logic        frame_last_o
);

    localparam logic [1:0] S_IDLE  = 2'd0;
    localparam logic [1:0] S_ISSUE = 2'd1;
    localparam logic [1:0] S_WAIT  = 2'd2;
    localparam logic [1:0] S_SHOW  = 2'd3;

    logic [1:0]  state;
    logic [7:0]  bx;
    logic [7:0]  by;
    logic [1:0]  row;
    logic [31:0] word_addr;

    assign word_addr    = ((32'(by) << 2) + 32'(row)) * `FRAME_W_BLK + 32'(bx);
    assign blk.blk_x    = bx;
    assign blk.blk_y    = by;
    assign frame_last_o = (bx == 8'(`FRAME_W_BLK - 1)) && (by == 8'(`FRAME_H_BLK - 1));

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state        <= S_IDLE;
            fetch_req_o  <= 1'b0;
            fetch_addr_o <= '0;
            blk.valid    <= 1'b0;
            bx           <= '0;
            by           <= '0;
            row          <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start_i) begin
                        bx           <= '0;
                        by           <= '0;
                        row          <= '0;
                        fetch_req_o  <= 1'b1;
                        fetch_addr_o <= '0;
                        state        <= S_WAIT;
                    end
                end
                S_ISSUE: begin
                    fetch_req_o  <= 1'b1;
                    fetch_addr_o <= word_addr;
                    state        <= S_WAIT;
                end
                S_WAIT: begin
                    if (data_valid_i) begin
                        fetch_req_o <= 1'b0;
                        if (row == 2'd3) begin
                            blk.valid <= 1'b1;
                            state     <= S_SHOW;
                        end else begin
                            row   <= row + 2'd1;
                            state <= S_ISSUE;
                        end
                    end
                end
                default: begin
                    // hold the block until the intra stage takes it
                    if (blk.ready) begin
                        blk.valid <= 1'b0;
                        row       <= '0;
                        if (frame_last_o) begin
                            state <= S_IDLE;
                        end else begin
                            state <= S_ISSUE;
                            if (bx == 8'(`FRAME_W_BLK - 1)) begin
                                bx <= '0;
                                by <= by + 8'd1;
                            end else begin
                                bx <= bx + 8'd1;
                            end
                        end
                    end
                end
            endcase
        end
    end

    // byte 3 is the leftmost pixel of the row
    always_ff @(posedge clk) begin
        if (state == S_WAIT && data_valid_i) begin
            for (int c = 0; c < 4; c++) begin
                blk.pix[4 * row + c] <= data_word_i[31 - `PIX_W * c -: `PIX_W];
            end
        end
    end

endmodule

/* hw/intra_dct_quant.sv */
`timescale 1ns/100ps
`include "enc_consts.svh"

module intra_dct_quant
    import enc_pkg::*;
(
    input  logic clk,
    input  logic reset_i,
    input  logic frame_last_i,
    blk_if.dst   blk,
    coef_if.src  coef
);

    localparam int QBITS   = quant_bits(`ENC_QP);
    localparam int QOFFSET = (1 << QBITS) / 3;
    localparam int QP_MOD  = `ENC_QP % 6;

    logic                      v1;
    logic                      v2;
    logic                      last1;
    logic                      last2;
    logic                      adv1;
    logic                      adv2;
    logic                      adv3;
    logic [3:0][`PIX_W-1:0]    left_col;
    logic [`PIX_W+1:0]         left_sum;
    logic [`PIX_W-1:0]         pred;
    logic [15:0][15:0]         row_t;
    logic [15:0][15:0]         r1;
    logic [15:0][15:0]         col_t;
    logic [15:0][15:0]         c2;
    logic [15:0][`LEVEL_W-1:0] q_t;

    // forward core transform butterfly
    function automatic logic [3:0][15:0] fwd4(input logic [3:0][15:0] x);
        logic signed [15:0] s0;
        logic signed [15:0] s1;
        logic signed [15:0] d0;
        logic signed [15:0] d1;
        logic [3:0][15:0]   y;
        s0   = $signed(x[0]) + $signed(x[3]);
        s1   = $signed(x[1]) + $signed(x[2]);
        d0   = $signed(x[0]) - $signed(x[3]);
        d1   = $signed(x[1]) - $signed(x[2]);
        y[0] = s0 + s1;
        y[1] = (d0 <<< 1) + d1;
        y[2] = s0 - s1;
        y[3] = d0 - (d1 <<< 1);
        return y;
    endfunction

    // a stage moves when the next one is empty or draining
    assign adv3      = !coef.valid || coef.ready;
    assign adv2      = !v2 || adv3;
    assign adv1      = !v1 || adv2;
    assign blk.ready = adv1;

    // dc from the left block's right column or 128 at the left edge
    assign left_sum = (`PIX_W+2)'(left_col[0]) + (`PIX_W+2)'(left_col[1])
                    + (`PIX_W+2)'(left_col[2]) + (`PIX_W+2)'(left_col[3]);
    assign pred = (blk.blk_x != 8'd0) ?
                  `PIX_W'((left_sum + (`PIX_W+2)'(2)) >> 2) : `PIX_W'(128);

    always_comb begin
        logic [3:0][15:0]   x;
        logic signed [15:0] a;
        logic signed [15:0] b;
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                a    = 16'(blk.pix[4 * r + c]);
                b    = 16'(pred);
                x[c] = a - b;
            end
            row_t[4 * r +: 4] = fwd4(x);
        end
    end

    always_comb begin
        logic [3:0][15:0] x;
        logic [3:0][15:0] y;
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                x[r] = r1[4 * r + c];
            end
            y = fwd4(x);
            for (int r = 0; r < 4; r++) begin
                col_t[4 * r + c] = y[r];
            end
        end
    end

    always_comb begin
        logic signed [15:0] cf;
        logic [15:0]        mag;
        logic [31:0]        qv;
        int                 cls;
        for (int i = 0; i < 16; i++) begin
            cf  = $signed(c2[i]);
            mag = cf[15] ? 16'(-cf) : 16'(cf);
            // row parity is bit 2 and column parity bit 0
            cls = (((i >> 2) & 1) == 0 && (i & 1) == 0) ? 0 :
                  (((i >> 2) & 1) == 1 && (i & 1) == 1) ? 1 : 2;
            qv  = (32'(mag) * 32'(quant_mf(QP_MOD, cls)) + 32'(QOFFSET)) >> QBITS;
            q_t[i] = cf[15] ? `LEVEL_W'(-qv) : `LEVEL_W'(qv);
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            v1         <= 1'b0;
            v2         <= 1'b0;
            coef.valid <= 1'b0;
        end else begin
            if (adv1) v1 <= blk.valid;
            if (adv2) v2 <= v1;
            if (adv3) coef.valid <= v2;
        end
    end

    always_ff @(posedge clk) begin
        if (adv1 && blk.valid) begin
            r1     <= row_t;
            last1  <= frame_last_i;
            for (int r = 0; r < 4; r++) begin
                left_col[r] <= blk.pix[4 * r + 3];
            end
        end
        if (adv2 && v1) begin
            c2    <= col_t;
            last2 <= last1;
        end
        if (adv3 && v2) begin
            coef.level <= q_t;
            coef.last  <= last2;
        end
    end

endmodule

/* hw/coef_expgolomb.sv */
`timescale 1ns/100ps
`include "enc_consts.svh"

module coef_expgolomb
    import enc_pkg::*;
(
    input  logic clk,
    input  logic reset_i,
    coef_if.dst  coef,
    code_if.src  code
);

    logic                        busy;
    logic                        blk_last;
    logic [3:0]                  idx;
    logic [15:0][`LEVEL_W-1:0]   lv_q;
    logic signed [`LEVEL_W+1:0]  lv;
    logic [`LEVEL_W+1:0]         uval;
    logic [`LEVEL_W+1:0]         vp1;
    logic [`LEN_W-1:0]           nbits;

    assign coef.ready = !busy;
    assign code.valid = busy;
    assign code.last  = blk_last && (idx == 4'd15);
    assign code.code  = `CODE_W'(vp1);
    // nbits-1 leading zeros in front of the nbits of value+1
    assign code.len   = (nbits << 1) - `LEN_W'(1);

    always_comb begin
        lv    = $signed(lv_q[zigzag_pos(idx)]);
        // signed to unsigned mapping, positive values take the odd codes
        uval  = (lv > 0) ? (lv <<< 1) - 1 : -(lv <<< 1);
        vp1   = uval + 1'b1;
        nbits = '0;
        for (int b = 0; b < `LEVEL_W + 2; b++) begin
            if (vp1[b]) nbits = `LEN_W'(b + 1);
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            busy <= 1'b0;
            idx  <= '0;
        end else if (!busy) begin
            if (coef.valid) begin
                busy <= 1'b1;
                idx  <= '0;
            end
        end else if (code.ready) begin
            idx <= idx + 4'd1;
            if (idx == 4'd15) busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (coef.valid && coef.ready) begin
            lv_q     <= coef.level;
            blk_last <= coef.last;
        end
    end

endmodule

/* hw/bit_packer.sv */
`timescale 1ns/100ps
`include "enc_consts.svh"

module bit_packer (
    input  logic        clk,
    input  logic        reset_i,
    code_if.dst         code,
    output logic        out_valid_o,
    output logic [31:0] out_word_o,
    output logic [31:0] out_addr_o,
    output logic        done_o
);

    // valid bits sit at the top of acc, everything below fill is zero
    logic [63:0] acc;
    logic [63:0] acc_sh;
    logic [6:0]  fill;
    logic [6:0]  base;
    logic        flushing;
    logic        emit;
    logic        take;
    logic [31:0] wr_cnt;

    assign code.ready = !flushing;
    assign take       = code.valid && !flushing;
    assign emit       = (fill >= 7'd32) || (flushing && fill != 7'd0);
    assign acc_sh     = emit ? {acc[31:0], 32'b0} : acc;
    assign base       = emit ? ((fill >= 7'd32) ? fill - 7'd32 : 7'd0) : fill;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            acc         <= '0;
            fill        <= '0;
            flushing    <= 1'b0;
            wr_cnt      <= '0;
            out_valid_o <= 1'b0;
            out_word_o  <= '0;
            out_addr_o  <= '0;
            done_o      <= 1'b0;
        end else begin
            out_valid_o <= emit;
            done_o      <= 1'b0;
            if (emit) begin
                out_word_o <= acc[63:32];
                out_addr_o <= wr_cnt;
                wr_cnt     <= wr_cnt + 32'd1;
            end
            if (take) begin
                acc  <= acc_sh | ({32'b0, code.code} << (7'd64 - base - 7'(code.len)));
                fill <= base + 7'(code.len);
                if (code.last) flushing <= 1'b1;
            end else begin
                acc  <= acc_sh;
                fill <= base;
            end
            // last partial word already went out, close the frame
            if (flushing && fill == 7'd0) begin
                flushing <= 1'b0;
                done_o   <= 1'b1;
                wr_cnt   <= '0;
            end
        end
    end

endmodule

/* hw/enc_top.sv */
`timescale 1ns/100ps

module enc_top (
    input  logic        clk,
    input  logic        reset_i,
    input  logic        start_i,
    input  logic        data_valid_i,
    input  logic [31:0] data_word_i,
    output logic        fetch_req_o,
    output logic [31:0] fetch_addr_o,
    output logic        out_valid_o,
    output logic [31:0] out_word_o,
    output logic [31:0] out_addr_o,
    output logic        done_o
);

    logic frame_last;

    blk_if  blk_bus ();
    coef_if coef_bus ();
    code_if code_bus ();

    block_fetch u_fetch (
        .clk          (clk),
        .reset_i      (reset_i),
        .start_i      (start_i),
        .data_valid_i (data_valid_i),
        .data_word_i  (data_word_i),
        .fetch_req_o  (fetch_req_o),
        .fetch_addr_o (fetch_addr_o),
        .blk          (blk_bus),
        .frame_last_o (frame_last)
    );

    intra_dct_quant u_intra (
        .clk          (clk),
        .reset_i      (reset_i),
        .frame_last_i (frame_last),
        .blk          (blk_bus),
        .coef         (coef_bus)
    );

    coef_expgolomb u_coder (
        .clk     (clk),
        .reset_i (reset_i),
        .coef    (coef_bus),
        .code    (code_bus)
    );

    bit_packer u_packer (
        .clk         (clk),
        .reset_i     (reset_i),
        .code        (code_bus),
        .out_valid_o (out_valid_o),
        .out_word_o  (out_word_o),
        .out_addr_o  (out_addr_o),
        .done_o      (done_o)
    );

endmodule

/* testbench/enc_assert.sv */
`timescale 1ns/100ps

module enc_assert (
    input logic        clk,
    input logic        reset_i,
    input logic        fetch_req_i,
    input logic [31:0] fetch_addr_i,
    input logic        data_valid_i,
    input logic        blk_valid_i,
    input logic        blk_ready_i,
    input logic        coef_valid_i,
    input logic        coef_ready_i,
    input logic        code_valid_i,
    input logic        code_ready_i,
    input logic        out_valid_i,
    input logic        done_i
);

    int fail_count = 0;

    // request and address hold until the memory answers
    req_hold: assert property (@(posedge clk) disable iff (reset_i)
        fetch_req_i && !data_valid_i |=> fetch_req_i && $stable(fetch_addr_i))
        else begin
            $error("fetch request dropped or moved before data returned");
            fail_count++;
        end

    blk_hold: assert property (@(posedge clk) disable iff (reset_i)
        blk_valid_i && !blk_ready_i |=> blk_valid_i)
        else begin
            $error("block valid dropped without ready");
            fail_count++;
        end

    coef_hold: assert property (@(posedge clk) disable iff (reset_i)
        coef_valid_i && !coef_ready_i |=> coef_valid_i)
        else begin
            $error("coefficient valid dropped without ready");
            fail_count++;
        end

    code_hold: assert property (@(posedge clk) disable iff (reset_i)
        code_valid_i && !code_ready_i |=> code_valid_i)
        else begin
            $error("codeword valid dropped without ready");
            fail_count++;
        end

    // done comes one cycle after the last output word
    done_after_word: assert property (@(posedge clk) disable iff (reset_i)
        done_i |-> $past(out_valid_i))
        else begin
            $error("done without a preceding output word");
            fail_count++;
        end

endmodule

bind enc_top enc_assert u_assert (
    .clk          (clk),
    .reset_i      (reset_i),
    .fetch_req_i  (fetch_req_o),
    .fetch_addr_i (fetch_addr_o),
    .data_valid_i (data_valid_i),
    .blk_valid_i  (blk_bus.valid),
    .blk_ready_i  (blk_bus.ready),
    .coef_valid_i (coef_bus.valid),
    .coef_ready_i (coef_bus.ready),
    .code_valid_i (code_bus.valid),
    .code_ready_i (code_bus.ready),
    .out_valid_i  (out_valid_o),
    .done_i       (done_o)
);

/* testbench/enc_tb.sv */
`timescale 1ns/100ps
`include "enc_consts.svh"

module enc_tb;

    localparam int BLOCKS         = `FRAME_W_BLK * `FRAME_H_BLK;
    localparam int MEM_WORDS      = BLOCKS * 4;
    localparam int MAX_WORDS      = 256;
    localparam int NUM_TESTS      = 4;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * BLOCKS * (4 * 6 + 40) + 2000;
    localparam int ZZ_ORDER [16]  = '{0, 1, 4, 8, 5, 2, 3, 6, 9, 12, 13, 10, 7, 11, 14, 15};
    localparam int TMAT [4][4]    = '{'{1, 1, 1, 1}, '{2, 1, -1, -2},
                                      '{1, -1, -1, 1}, '{1, -2, 2, -1}};

    logic        clk = 1'b0;
    logic        reset_i;
    logic        start_i;
    logic        data_valid_i = 1'b0;
    logic [31:0] data_word_i = '0;
    logic        fetch_req_o;
    logic [31:0] fetch_addr_o;
    logic        out_valid_o;
    logic [31:0] out_word_o;
    logic [31:0] out_addr_o;
    logic        done_o;

    logic [31:0] frame_mem [MEM_WORDS];
    logic [31:0] exp_words [MAX_WORDS];
    logic [31:0] got_words [MAX_WORDS];
    logic [31:0] got_addr [MAX_WORDS];
    int          exp_count;
    int          got_count = 0;
    int          done_count = 0;
    int          err_count = 0;
    int          cycle_count = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          test_err_base;
    string       test_name;
    logic        mem_pending = 1'b0;
    int          mem_delay = 0;

    always #2 clk = ~clk;

    enc_top i_dut (
        .clk          (clk),
        .reset_i      (reset_i),
        .start_i      (start_i),
        .data_valid_i (data_valid_i),
        .data_word_i  (data_word_i),
        .fetch_req_o  (fetch_req_o),
        .fetch_addr_o (fetch_addr_o),
        .out_valid_o  (out_valid_o),
        .out_word_o   (out_word_o),
        .out_addr_o   (out_addr_o),
        .done_o       (done_o)
    );

    task automatic check_val(input string what, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s got %0h, expected %0h", $time, what, got, exp);
            err_count++;
        end
    endtask

    // value mismatches plus bound assertion failures
    function automatic int total_errors();
        return err_count + i_dut.u_assert.fail_count;
    endfunction

    // standard quantizer multipliers by qp%6 and position class
    function automatic int std_quant_mult(input int qp_mod, input int cls);
        int tbl [6][3];
        tbl = '{'{13107, 5243, 8066}, '{11916, 4660, 7490}, '{10082, 4194, 6554},
                '{9362, 3647, 5825}, '{8192, 3355, 5243}, '{7282, 2893, 4559}};
        return tbl[qp_mod][cls];
    endfunction

    function automatic int pixel_at(input int x, input int y);
        logic [31:0] w;
        w = frame_mem[y * `FRAME_W_BLK + x / 4];
        return int'(w[8 * (3 - x % 4) +: 8]);
    endfunction

    // expected packed bitstream of the whole frame
    function automatic int ref_encode();
        int          res [4][4];
        int          tmp [4][4];
        int          lvl [16];
        int          pred;
        int          w;
        int          mag;
        int          cls;
        int          qbits;
        int          u;
        int          n;
        int          count;
        int          nbits;
        logic [31:0] cur;
        count = 0;
        nbits = 0;
        cur   = '0;
        qbits = 15 + `ENC_QP / 6;
        for (int by = 0; by < `FRAME_H_BLK; by++) begin
            for (int bx = 0; bx < `FRAME_W_BLK; bx++) begin
                pred = 128;
                if (bx > 0) begin
                    pred = 2;
                    for (int r = 0; r < 4; r++) begin
                        pred += pixel_at(bx * 4 - 1, by * 4 + r);
                    end
                    pred = pred / 4;
                end
                for (int r = 0; r < 4; r++) begin
                    for (int c = 0; c < 4; c++) begin
                        res[r][c] = pixel_at(bx * 4 + c, by * 4 + r) - pred;
                    end
                end
                // C * X * C^T
                for (int r = 0; r < 4; r++) begin
                    for (int k = 0; k < 4; k++) begin
                        tmp[r][k] = 0;
                        for (int c = 0; c < 4; c++) begin
                            tmp[r][k] += TMAT[k][c] * res[r][c];
                        end
                    end
                end
                for (int k = 0; k < 4; k++) begin
                    for (int c = 0; c < 4; c++) begin
                        w = 0;
                        for (int r = 0; r < 4; r++) begin
                            w += TMAT[k][r] * tmp[r][c];
                        end
                        mag = (w < 0) ? -w : w;
                        cls = (k % 2 == 0 && c % 2 == 0) ? 0 :
                              (k % 2 == 1 && c % 2 == 1) ? 1 : 2;
                        mag = (mag * std_quant_mult(`ENC_QP % 6, cls)
                               + (1 << qbits) / 3) >> qbits;
                        lvl[4 * k + c] = (w < 0) ? -mag : mag;
                    end
                end
                for (int i = 0; i < 16; i++) begin
                    u = (lvl[ZZ_ORDER[i]] > 0) ? 2 * lvl[ZZ_ORDER[i]] - 1
                                               : -2 * lvl[ZZ_ORDER[i]];
                    n = 0;
                    while (((u + 1) >> n) != 0) n++;
                    // value+1 in 2n-1 bits carries its own zero prefix
                    for (int b = 0; b < 2 * n - 1; b++) begin
                        cur = {cur[30:0], 1'(((u + 1) >> (2 * n - 2 - b)) & 1)};
                        nbits++;
                        if (nbits == 32) begin
                            exp_words[count] = cur;
                            count++;
                            nbits = 0;
                        end
                    end
                end
            end
        end
        if (nbits > 0) begin
            exp_words[count] = cur << (32 - nbits);
            count++;
        end
        return count;
    endfunction

    // kind selects flat (0), random (1) or gradient (2)
    task automatic load_image(input int kind);
        int x;
        int y;
        for (int a = 0; a < MEM_WORDS; a++) begin
            y = a / `FRAME_W_BLK;
            if (kind == 1) begin
                frame_mem[a] = $urandom;
            end else begin
                for (int c = 0; c < 4; c++) begin
                    x = (a % `FRAME_W_BLK) * 4 + c;
                    frame_mem[a][8 * (3 - c) +: 8] = (kind == 0) ? 8'd128 : 8'(x * 15 + y * 21);
                end
            end
        end
    endtask

    task automatic encode_frame();
        int done_before;
        exp_count   = ref_encode();
        done_before = done_count;
        @(posedge clk);
        start_i <= 1'b1;
        @(posedge clk);
        start_i <= 1'b0;
        while (done_count == done_before) @(posedge clk);
        // no second done and no stray words afterwards
        repeat (20) @(posedge clk);
        check_val("done pulses", done_count - done_before, 1);
        check_val("words after done", got_count, 0);
    endtask

    task automatic begin_test(input string name);
        test_name     = name;
        test_err_base = total_errors();
    endtask

    task automatic end_test();
        tests_run++;
        if (total_errors() == test_err_base) begin
            $display("test %0d %s: ok", tests_run, test_name);
        end else begin
            tests_failed++;
            $display("test %0d %s: FAILED, %0d errors", tests_run, test_name,
                     total_errors() - test_err_base);
        end
    endtask

    task automatic compare_frame();
        check_val("word count", got_count, exp_count);
        for (int i = 0; i < got_count && i < exp_count; i++) begin
            check_val($sformatf("word %0d", i), got_words[i], exp_words[i]);
        end
        for (int i = 0; i < got_count; i++) begin
            check_val($sformatf("address of word %0d", i), got_addr[i], i);
        end
    endtask

    // memory model answering each request after a random wait
    always @(posedge clk) begin
        if (reset_i) begin
            data_valid_i <= 1'b0;
            mem_pending  <= 1'b0;
        end else begin
            data_valid_i <= 1'b0;
            if (fetch_req_o && !data_valid_i) begin
                if (!mem_pending) begin
                    mem_pending <= 1'b1;
                    mem_delay   <= int'($urandom % 4) + 1;
                end else if (mem_delay <= 1) begin
                    mem_pending  <= 1'b0;
                    data_valid_i <= 1'b1;
                    data_word_i  <= frame_mem[fetch_addr_o];
                end else begin
                    mem_delay <= mem_delay - 1;
                end
            end
        end
    end

    // output word capture and frame compare on done
    always @(posedge clk) begin
        if (reset_i) begin
            got_count <= 0;
        end else begin
            if (out_valid_o && got_count < MAX_WORDS) begin
                got_words[got_count] <= out_word_o;
                got_addr[got_count]  <= out_addr_o;
                got_count            <= got_count + 1;
            end
            if (done_o) begin
                done_count <= done_count + 1;
                compare_frame();
                got_count <= 0;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: encoder did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("sim failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'h2593_a03f));
        reset_i = 1'b1;
        start_i = 1'b0;
        repeat (10) @(posedge clk);
        reset_i <= 1'b0;

        begin_test("flat image");
        load_image(0);
        encode_frame();
        // 192 single-bit codewords
        check_val("flat reference count", exp_count, 6);
        for (int i = 0; i < 6; i++) begin
            check_val($sformatf("flat output word %0d", i), got_words[i], 32'hffff_ffff);
        end
        end_test();

        begin_test("random image");
        load_image(1);
        encode_frame();
        end_test();

        begin_test("restart with new random image");
        load_image(1);
        encode_frame();
        end_test();

        begin_test("reset mid-frame then gradient image");
        load_image(1);
        @(posedge clk);
        start_i <= 1'b1;
        @(posedge clk);
        start_i <= 1'b0;
        while (got_count < 2) @(posedge clk);
        reset_i <= 1'b1;
        repeat (10) @(posedge clk);
        check_val("fetch_req_o in reset", fetch_req_o, 0);
        check_val("fetch_addr_o in reset", fetch_addr_o, 0);
        check_val("out_valid_o in reset", out_valid_o, 0);
        check_val("out_word_o in reset", out_word_o, 0);
        check_val("out_addr_o in reset", out_addr_o, 0);
        check_val("done_o in reset", done_o, 0);
        reset_i <= 1'b0;
        load_image(2);
        encode_frame();
        end_test();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
                 total_errors());
        if (total_errors() == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+include
hw/enc_pkg.sv
hw/enc_if.sv
hw/block_fetch.sv
hw/intra_dct_quant.sv
hw/coef_expgolomb.sv
hw/bit_packer.sv
hw/enc_top.sv
testbench/enc_assert.sv
testbench/enc_tb.sv

/* Bender.yml */
package:
  name: enc_core

export_include_dirs:
  - include

sources:
  - hw/enc_pkg.sv
  - hw/enc_if.sv
  - hw/block_fetch.sv
  - hw/intra_dct_quant.sv
  - hw/coef_expgolomb.sv
  - hw/bit_packer.sv
  - hw/enc_top.sv
  - target: test
    files:
      - testbench/enc_assert.sv
      - testbench/enc_tb.sv
